/* hw/conv_defines.svh */
`ifndef CONV_DEFINES_SVH
`define CONV_DEFINES_SVH

// **************************************************************************
// Map and kernel geometry.
// **************************************************************************
`define CONV_MAP_WIDTH  32
`define CONV_KERNEL     5
`define CONV_OUT_WIDTH  (`CONV_MAP_WIDTH - `CONV_KERNEL + 1)

// **************************************************************************
// Data widths.
// **************************************************************************
`define CONV_PIX_BITS   8       // Unsigned pixels.
`define CONV_W_BITS     8       // Signed weights.
`define CONV_ACC_BITS   21      // 25 products of 255 x -128 still fit.
`define CONV_COUNT_BITS 9       // Fill count reaches 132.

`endif

/* hw/conv_pkg.sv */
`default_nettype none

`include "conv_defines.svh"

package conv_pkg;

    // Phases of the window timing. The fill covers the first four rows plus
    // four pixels, after that valid runs and gaps alternate once per map row.
    typedef enum logic [1:0] {
        idle      = 2'b00,
        fill      = 2'b01,
        valid_run = 2'b10,
        gap       = 2'b11
    } win_state_t;

    typedef logic        [`CONV_PIX_BITS-1:0]   pixel_t;
    typedef logic signed [`CONV_W_BITS-1:0]     weight_t;
    typedef logic signed [`CONV_ACC_BITS-1:0]   acc_t;
    typedef logic        [`CONV_COUNT_BITS-1:0] count_t;

endpackage

`default_nettype wire

/* hw/flag_counter.sv */
`timescale 1ns/1ns
`default_nettype none

`include "conv_defines.svh"

module flag_counter import conv_pkg::*; (
    input  logic clk,
    input  logic nrst,
    input  logic start,
    input  logic map_finish,
    output logic win_valid,
    output logic row_flag
);

    // Last count value of each phase.
    localparam count_t fill_last =
        count_t'((`CONV_KERNEL - 1) * `CONV_MAP_WIDTH + `CONV_KERNEL - 1);
    localparam count_t run_last  = count_t'(`CONV_OUT_WIDTH - 1);
    localparam count_t gap_last  = count_t'(`CONV_KERNEL - 2);

    win_state_t state;
    win_state_t next_state;
    count_t     count;
    count_t     next_count;

    always_ff @(posedge clk or negedge nrst) begin
        if (!nrst) begin
            state     <= idle;
            count     <= '0;
            win_valid <= 1'b0;
            row_flag  <= 1'b0;
        end else if (map_finish) begin  // End of map, back to idle.
            state     <= idle;
            count     <= '0;
            win_valid <= 1'b0;
            row_flag  <= 1'b0;
        end else begin
            state     <= next_state;
            count     <= next_count;
            win_valid <= (next_state == valid_run);
            row_flag  <= (next_state == valid_run) && (state != valid_run);
        end
    end

    always_comb begin
        next_state = state;
        next_count = count + 1'b1;
        case (state)
            idle: begin
                next_count = '0;
                if (start) next_state = fill;
            end
            fill: begin
                if (count == fill_last) begin
                    next_state = valid_run;
                    next_count = '0;
                end
            end
            valid_run: begin
                if (count == run_last) begin
                    next_state = gap;
                    next_count = '0;
                end
            end
            gap: begin
                // The window slides across the row wrap here.
                if (count == gap_last) begin
                    next_state = valid_run;
                    next_count = '0;
                end
            end
        endcase
    end

endmodule

`default_nettype wire

/* hw/window_buffer.sv */
`timescale 1ns/1ns
`default_nettype none

`include "conv_defines.svh"

module window_buffer import conv_pkg::*; (
    input  logic   clk,
    input  logic   nrst,
    input  pixel_t pix_data,
    output pixel_t window [`CONV_KERNEL*`CONV_KERNEL]
);

    pixel_t line_buf [`CONV_KERNEL-1][`CONV_MAP_WIDTH];
    pixel_t row_tap  [`CONV_KERNEL];

    // The bottom window row is the live stream. Each line buffer holds one
    // full map row, so its output is the same column one row higher up.
    assign row_tap[`CONV_KERNEL-1] = pix_data;

    for (genvar i = 0; i < `CONV_KERNEL - 1; i++) begin : g_tap
        assign row_tap[`CONV_KERNEL-2-i] = line_buf[i][`CONV_MAP_WIDTH-1];
    end

    // **************************************************************************
    // Line buffers, one shift per pixel.
    // **************************************************************************
    always_ff @(posedge clk) begin
        for (int i = 0; i < `CONV_KERNEL - 1; i++) begin
            line_buf[i][0] <= row_tap[`CONV_KERNEL-1-i];
            for (int j = 1; j < `CONV_MAP_WIDTH; j++) begin
                line_buf[i][j] <= line_buf[i][j-1];
            end
        end
    end

    // **************************************************************************
    // 5x5 window, newest pixel enters at the right of each row.
    // **************************************************************************
    always_ff @(posedge clk or negedge nrst) begin
        if (!nrst) begin
            for (int k = 0; k < `CONV_KERNEL * `CONV_KERNEL; k++) begin
                window[k] <= '0;
            end
        end else begin
            for (int r = 0; r < `CONV_KERNEL; r++) begin
                for (int c = 0; c < `CONV_KERNEL - 1; c++) begin
                    window[r*`CONV_KERNEL+c] <= window[r*`CONV_KERNEL+c+1];
                end
                window[r*`CONV_KERNEL+`CONV_KERNEL-1] <= row_tap[r];
            end
        end
    end

endmodule

`default_nettype wire

/* hw/kernel_regs.sv */
`timescale 1ns/1ns
`default_nettype none

`include "conv_defines.svh"

module kernel_regs import conv_pkg::*; (
    input  logic       clk,
    input  logic       nrst,
    input  logic       w_we,
    input  logic [4:0] w_addr,
    input  weight_t    w_data,
    output weight_t    weights [`CONV_KERNEL*`CONV_KERNEL]
);

    // One write port, all weights read in parallel. Addresses 25 to 31 match
    // no register and are dropped.
    always_ff @(posedge clk or negedge nrst) begin
        if (!nrst) begin
            for (int i = 0; i < `CONV_KERNEL * `CONV_KERNEL; i++) begin
                weights[i] <= '0;
            end
        end else if (w_we) begin
            for (int i = 0; i < `CONV_KERNEL * `CONV_KERNEL; i++) begin
                if (w_addr == 5'(i)) weights[i] <= w_data;
            end
        end
    end

endmodule

`default_nettype wire

/* hw/mac_tree.sv */
`timescale 1ns/1ns
`default_nettype none

`include "conv_defines.svh"

module mac_tree import conv_pkg::*; (
    input  logic    clk,
    input  logic    nrst,
    input  logic    win_valid,
    input  logic    row_flag,
    input  pixel_t  window  [`CONV_KERNEL*`CONV_KERNEL],
    input  weight_t weights [`CONV_KERNEL*`CONV_KERNEL],
    output acc_t    out_data,
    output logic    out_valid,
    output logic    out_row_start
);

    acc_t       row_sum   [`CONV_KERNEL];
    acc_t       row_sum_q [`CONV_KERNEL];
    acc_t       total;
    logic [1:0] valid_sr;
    logic [1:0] row_sr;

    // Pixel is unsigned, so it is widened with zeros before the signed multiply.
    function automatic acc_t pix_mul(input pixel_t p, input weight_t w);
        return acc_t'(p) * acc_t'(w);
    endfunction

    always_comb begin
        for (int r = 0; r < `CONV_KERNEL; r++) begin
            row_sum[r] = '0;
            for (int c = 0; c < `CONV_KERNEL; c++) begin
                row_sum[r] = row_sum[r] + pix_mul(window[r*`CONV_KERNEL+c],
                                                  weights[r*`CONV_KERNEL+c]);
            end
        end
    end

    always_comb begin
        total = '0;
        for (int r = 0; r < `CONV_KERNEL; r++) total = total + row_sum_q[r];
    end

    // **************************************************************************
    // Two register stages, row partials then total.
    // **************************************************************************
    always_ff @(posedge clk) begin
        row_sum_q <= row_sum;
        out_data  <= total;
    end

    always_ff @(posedge clk or negedge nrst) begin
        if (!nrst) begin
            valid_sr <= '0;
            row_sr   <= '0;
        end else begin
            valid_sr <= {valid_sr[0], win_valid};
            row_sr   <= {row_sr[0], row_flag};
        end
    end

    assign out_valid     = valid_sr[1];
    assign out_row_start = row_sr[1];   // Tags column 0 of each output row.

endmodule

`default_nettype wire

/* hw/map_sequencer.sv */
`timescale 1ns/1ns
`default_nettype none

`include "conv_defines.svh"

module map_sequencer import conv_pkg::*; (
    input  logic clk,
    input  logic nrst,
    input  logic row_flag,
    input  logic win_valid,
    output logic map_finish,
    output logic done
);

    localparam logic [4:0] rows_per_map = 5'(`CONV_OUT_WIDTH);

    logic [4:0] row_count;
    logic       win_valid_d;
    logic [1:0] finish_sr;

    always_ff @(posedge clk or negedge nrst) begin
        if (!nrst) begin
            row_count   <= '0;
            win_valid_d <= 1'b0;
            finish_sr   <= '0;
        end else begin
            win_valid_d <= win_valid;
            finish_sr   <= {finish_sr[0], map_finish};
            if (map_finish) begin
                row_count <= '0;                // Ready for the next map.
            end else if (row_flag) begin
                row_count <= row_count + 1'b1;
            end
        end
    end

    // First gap cycle after the last valid run of the map.
    assign map_finish = win_valid_d && !win_valid && (row_count == rows_per_map);

    // Two stages so done lands one cycle after the last result leaves mac_tree.
    assign done = finish_sr[1];

endmodule

`default_nettype wire

/* hw/conv5x5_top.sv */
`timescale 1ns/1ns
`default_nettype none

`include "conv_defines.svh"

module conv5x5_top import conv_pkg::*; (
    input  logic       clk,
    input  logic       nrst,
    input  logic       start,
    input  pixel_t     pix_data,
    input  logic       w_we,
    input  logic [4:0] w_addr,
    input  weight_t    w_data,
    output acc_t       out_data,
    output logic       out_valid,
    output logic       out_row_start,
    output logic       done
);

    logic    win_valid;
    logic    row_flag;
    logic    map_finish;
    pixel_t  window  [`CONV_KERNEL*`CONV_KERNEL];
    weight_t weights [`CONV_KERNEL*`CONV_KERNEL];

    // **************************************************************************
    // Window timing and map control.
    // **************************************************************************
    flag_counter i_flag_counter (
        .clk        (clk),
        .nrst       (nrst),
        .start      (start),
        .map_finish (map_finish),
        .win_valid  (win_valid),
        .row_flag   (row_flag)
    );

    map_sequencer i_map_sequencer (
        .clk        (clk),
        .nrst       (nrst),
        .row_flag   (row_flag),
        .win_valid  (win_valid),
        .map_finish (map_finish),
        .done       (done)
    );

    // **************************************************************************
    // Data path.
    // **************************************************************************
    window_buffer i_window_buffer (
        .clk      (clk),
        .nrst     (nrst),
        .pix_data (pix_data),
        .window   (window)
    );

    kernel_regs i_kernel_regs (
        .clk     (clk),
        .nrst    (nrst),
        .w_we    (w_we),
        .w_addr  (w_addr),
        .w_data  (w_data),
        .weights (weights)
    );

    mac_tree i_mac_tree (
        .clk           (clk),
        .nrst          (nrst),
        .win_valid     (win_valid),
        .row_flag      (row_flag),
        .window        (window),
        .weights       (weights),
        .out_data      (out_data),
        .out_valid     (out_valid),
        .out_row_start (out_row_start)
    );

endmodule

`default_nettype wire

/* tb/conv5x5_properties.sv */
`timescale 1ns/1ns
`default_nettype none

`include "conv_defines.svh"

module conv5x5_properties (
    input logic clk,
    input logic nrst,
    input logic out_valid,
    input logic out_row_start,
    input logic done
);

    logic [5:0] run_len;    // Length of the current out_valid run.

    always_ff @(posedge clk or negedge nrst) begin
        if (!nrst) begin
            run_len <= '0;
        end else if (out_valid) begin
            run_len <= run_len + 6'd1;
        end else begin
            run_len <= '0;
        end
    end

    done_after_valid: assert property (@(posedge clk) disable iff (!nrst)
        !(out_valid && done)) else $error("done is high together with out_valid");

    row_start_in_run: assert property (@(posedge clk) disable iff (!nrst)
        out_row_start |-> out_valid) else $error("out_row_start without out_valid");

    // One output row per run, never longer and never cut short.
    run_not_too_long: assert property (@(posedge clk) disable iff (!nrst)
        out_valid |-> run_len < 6'(`CONV_OUT_WIDTH)) else $error("out_valid run too long");

    run_full_length: assert property (@(posedge clk) disable iff (!nrst)
        $fell(out_valid) |-> run_len == 6'(`CONV_OUT_WIDTH))
        else $error("out_valid run ended early");

    quiet_in_reset: assert property (@(posedge clk)
        !nrst |-> !out_valid && !out_row_start && !done)
        else $error("outputs active during reset");

endmodule

bind conv5x5_top conv5x5_properties i_properties (
    .clk           (clk),
    .nrst          (nrst),
    .out_valid     (out_valid),
    .out_row_start (out_row_start),
    .done          (done)
);

`default_nettype wire

/* tb/conv5x5_tb.sv */
`timescale 1ns/1ns
`default_nettype none

`include "conv_defines.svh"

module conv5x5_tb;

    localparam int map_pixels = `CONV_MAP_WIDTH * `CONV_MAP_WIDTH;
    localparam int taps       = `CONV_KERNEL * `CONV_KERNEL;
    localparam int results    = `CONV_OUT_WIDTH * `CONV_OUT_WIDTH;
    // Window (0,0) is complete with pixel 132, which enters on the 133rd edge
    // after start. mac_tree then adds two register stages.
    localparam int first_latency = (`CONV_KERNEL - 1) * `CONV_MAP_WIDTH + `CONV_KERNEL + 2;

    logic                             clk;
    logic                             nrst;
    logic                             start;
    logic [`CONV_PIX_BITS-1:0]        pix_data;
    logic                             w_we;
    logic [4:0]                       w_addr;
    logic [`CONV_W_BITS-1:0]          w_data;
    logic signed [`CONV_ACC_BITS-1:0] out_data;
    logic                             out_valid;
    logic                             out_row_start;
    logic                             done;

    int   seed = 78604;
    int   w_mem   [taps];
    int   pix_mem [map_pixels];
    int   edge_count = 0;
    int   start_edge = 0;
    int   last_valid_edge = 0;
    int   result_count = 0;
    logic map_active = 1'b0;

    conv5x5_top i_dut (
        .clk           (clk),
        .nrst          (nrst),
        .start         (start),
        .pix_data      (pix_data),
        .w_we          (w_we),
        .w_addr        (w_addr),
        .w_data        (w_data),
        .out_data      (out_data),
        .out_valid     (out_valid),
        .out_row_start (out_row_start),
        .done          (done)
    );

    always #50 clk = ~clk;

    always @(posedge clk) edge_count <= edge_count + 1;

    // **************************************************************************
    // Reference model and checks.
    // **************************************************************************
    function automatic int ref_conv(input int row, input int col);
        int sum;
        sum = 0;
        for (int kr = 0; kr < `CONV_KERNEL; kr++) begin
            for (int kc = 0; kc < `CONV_KERNEL; kc++) begin
                sum += pix_mem[(row + kr) * `CONV_MAP_WIDTH + col + kc]
                       * w_mem[kr * `CONV_KERNEL + kc];
            end
        end
        return sum;
    endfunction

    task automatic check(input logic signed [63:0] actual,
                         input logic signed [63:0] expected, input string what);
        if (actual !== expected) begin
            $display("FAILED at %0t: %s is %0d, expected %0d", $time, what, actual, expected);
            $display("TESTS FAILED");
            $fatal(1, "%s mismatch", what);
        end
    endtask

    task automatic abort_run(input string msg);
        $display("ERROR at %0t: %s", $time, msg);
        $display("TESTS FAILED");
        $fatal(1, "%s", msg);
    endtask

    // Results come in raster order, each at a fixed edge counted from start.
    always @(posedge clk or negedge nrst) begin : compare
        int row;
        int col;
        if (!nrst) begin
            map_active = 1'b0;
        end else begin
            if (start) begin
                map_active   = 1'b1;
                result_count = 0;
                start_edge   = edge_count;
            end
            if (out_valid) begin
                if (!map_active) begin
                    abort_run("out_valid was high while no map was running");
                end else if (result_count >= results) begin
                    abort_run("more results than the output map holds");
                end
                row = result_count / `CONV_OUT_WIDTH;
                col = result_count % `CONV_OUT_WIDTH;
                // The edge that set out_valid is the one before this one.
                check(edge_count - start_edge - 1,
                      first_latency + row * `CONV_MAP_WIDTH + col,
                      $sformatf("edges from start to result (%0d,%0d)", row, col));
                check(out_data, ref_conv(row, col),
                      $sformatf("out_data of result (%0d,%0d)", row, col));
                check(out_row_start, col == 0,
                      $sformatf("out_row_start of result (%0d,%0d)", row, col));
                last_valid_edge = edge_count;
                result_count++;
            end
            if (done) begin
                if (!map_active) begin
                    abort_run("done pulsed while no map was running");
                end
                check(result_count, results, "number of results before done");
                check(edge_count - last_valid_edge, 1, "cycles from last out_valid to done");
                map_active = 1'b0;
            end
        end
    end

    // **************************************************************************
    // Stimulus.
    // **************************************************************************
    task automatic apply_reset();
        nrst = 1'b0;
        repeat (4) @(posedge clk);
        @(negedge clk);
        nrst = 1'b1;
    endtask

    task automatic fill_random();
        for (int i = 0; i < taps; i++) w_mem[i] = ($random(seed) & 255) - 128;
        for (int i = 0; i < map_pixels; i++) pix_mem[i] = $random(seed) & 255;
    endtask

    task automatic fill_const(input int w, input int p);
        for (int i = 0; i < taps; i++) w_mem[i] = w;
        for (int i = 0; i < map_pixels; i++) pix_mem[i] = p;
    endtask

    task automatic load_weights();
        for (int i = 0; i < taps; i++) begin
            @(negedge clk);
            w_we   = 1'b1;
            w_addr = 5'(i);
            w_data = 8'(w_mem[i]);
        end
        @(negedge clk);
        w_we = 1'b0;
    endtask

    // One start pulse, then one pixel per edge with no gaps.
    task automatic stream_map(input int n_pix);
        @(negedge clk);
        start = 1'b1;
        @(negedge clk);
        start = 1'b0;
        for (int i = 0; i < n_pix; i++) begin
            pix_data = 8'(pix_mem[i]);
            @(negedge clk);
        end
        pix_data = '0;
    endtask

    task automatic wait_map_end();
        int n;
        n = 0;
        while (!out_valid && n < first_latency + 20) begin
            @(negedge clk);
            n++;
        end
        if (!out_valid) begin
            abort_run("timeout waiting for the first out_valid");
        end
        n = 0;
        while (!done && n < `CONV_OUT_WIDTH * `CONV_MAP_WIDTH + 20) begin
            @(negedge clk);
            n++;
        end
        if (!done) begin
            abort_run("timeout waiting for done");
        end
        repeat (2 * `CONV_KERNEL) @(negedge clk);  // Stray out_valid shows up here.
    endtask

    task automatic run_full_map();
        fork
            stream_map(map_pixels);
            wait_map_end();
        join
    endtask

    initial begin
        clk      = 1'b0;
        nrst     = 1'b0;
        start    = 1'b0;
        pix_data = '0;
        w_we     = 1'b0;
        w_addr   = '0;
        w_data   = '0;
        apply_reset();

        fill_random();
        load_weights();
        run_full_map();

        // Largest negative and positive sums.
        fill_const(-128, 255);
        check(ref_conv(0, 0), -816000, "reference sum for weights -128");
        load_weights();
        run_full_map();
        fill_const(127, 255);
        check(ref_conv(0, 0), 809625, "reference sum for weights 127");
        load_weights();
        run_full_map();

        // Second random map straight after done.
        fill_random();
        load_weights();
        run_full_map();

        // Reset halfway through a map. Weights are zero afterwards and are reloaded.
        fill_random();
        load_weights();
        stream_map(map_pixels / 2);
        apply_reset();
        repeat (200) @(negedge clk);
        load_weights();
        run_full_map();

        $display("TESTS PASSED");
        $finish;
    end

endmodule

`default_nettype wire

/* sources.f */
+incdir+hw
hw/conv_pkg.sv
hw/flag_counter.sv
hw/window_buffer.sv
hw/kernel_regs.sv
hw/mac_tree.sv
hw/map_sequencer.sv
hw/conv5x5_top.sv
tb/conv5x5_properties.sv
tb/conv5x5_tb.sv

/* Makefile */
# Verilator build for the 5x5 convolution engine.

VERILATOR ?= verilator
TOP       ?= conv5x5_tb
RTL_TOP   ?= conv5x5_top
SEED      ?= 78604
FILELIST  ?= sources.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert -Wno-fatal

RTL_SRCS  ?= hw/conv_pkg.sv hw/flag_counter.sv hw/window_buffer.sv hw/kernel_regs.sv \
             hw/mac_tree.sv hw/map_sequencer.sv hw/conv5x5_top.sv

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

# A $fatal in the testbench gives a non-zero exit status.
run: build
	./$(BUILD_DIR)/V$(TOP) +verilator+seed+$(SEED)

lint:
	$(VERILATOR) --lint-only -Wall -Ihw --top-module $(RTL_TOP) $(RTL_SRCS)

clean:
	rm -rf $(BUILD_DIR)
